//--- hw/storeQueue_params.svh
// Store queue sizing defines; include this wherever entry count or widths are needed.
`ifndef STORE_QUEUE_PARAMS_SVH
`define STORE_QUEUE_PARAMS_SVH

// Number of queue entries, a power of two.
// One entry always stays empty so head equal to tail means empty.
`define SQ_ENTRY_NUM 8

// Word address width.
`define SQ_ADDR_WIDTH 16

// Store data width.
`define SQ_DATA_WIDTH 32

`endif

//--- hw/StoreQueuePkg.sv
// Shared store queue types; referenced by scoped name from the RTL and the testbench.
`include "storeQueue_params.svh"

package StoreQueuePkg;

    // Entry index, wraps naturally at the entry count.
    typedef logic [$clog2(`SQ_ENTRY_NUM)-1:0] SqPtr;

    // Word address of a store or a load.
    typedef logic [`SQ_ADDR_WIDTH-1:0] SqAddr;

    // Store payload.
    typedef logic [`SQ_DATA_WIDTH-1:0] SqData;

    // Drain unit states.
    // Idle waits for a committed head, write holds the memory request.
    typedef enum logic [1:0] {
        DRAIN_IDLE  = 2'd0,
        DRAIN_WRITE = 2'd1
    } DrainState;

endpackage : StoreQueuePkg

//--- hw/CircularRangePicker.sv
// Circular range priority picker; picks the request closest below a tail within head..tail.

// Picks the youngest request in the circular range [headPtr, tailPtr).
// Head equal to tail covers no entries.
module CircularRangePicker #(
    parameter ENTRY_NUM = 8
)(
    input  logic [$clog2(ENTRY_NUM)-1:0] headPtr,
    input  logic [$clog2(ENTRY_NUM)-1:0] tailPtr,
    input  logic [ENTRY_NUM-1:0]         request,
    output logic [$clog2(ENTRY_NUM)-1:0] grantPtr,
    output logic                         picked
);
    localparam INDEX_BIT_SIZE = $clog2(ENTRY_NUM);

    // Doubled request vector feeding the shifter.
    logic [ENTRY_NUM*2-1:0] shifterIn;
    // Requests rotated so the entry just below tail sits at the top bit.
    logic [ENTRY_NUM-1:0] shiftedReq;
    // Highest set position in the rotated vector.
    logic [INDEX_BIT_SIZE-1:0] shiftedGrant;
    // Number of entries covered by the range.
    logic [INDEX_BIT_SIZE-1:0] rangeLen;
    // Lowest rotated position that still lies inside the range.
    logic [INDEX_BIT_SIZE:0] lowBound;
    logic anyReq;

    // Rotation by tailPtr.
    // Same as ({request, request} >> tailPtr) truncated to ENTRY_NUM bits.
    CircularRangePickerRightShifter #(
        .INPUT_WIDTH        (ENTRY_NUM*2),
        .SHIFT_AMOUNT_WIDTH (INDEX_BIT_SIZE),
        .OUTPUT_WIDTH       (ENTRY_NUM)
    ) rightShifter (
        .shiftIn     (shifterIn),
        .shiftAmount (tailPtr),
        .shiftOut    (shiftedReq)
    );

    always_comb begin
        shifterIn = {request, request};

        // Scan upward, the last hit is the highest request.
        anyReq = 1'b0;
        shiftedGrant = '0;
        for (int i = 0; i < ENTRY_NUM; i++) begin
            if (shiftedReq[i]) begin
                shiftedGrant = i[INDEX_BIT_SIZE-1:0];
                anyReq = 1'b1;
            end
        end

        // Undo the rotation.
        // The index width wraps the sum modulo ENTRY_NUM.
        grantPtr = shiftedGrant + tailPtr;

        // The range occupies rotated positions ENTRY_NUM-rangeLen up to ENTRY_NUM-1.
        rangeLen = tailPtr - headPtr;
        lowBound = (INDEX_BIT_SIZE+1)'(ENTRY_NUM) - {1'b0, rangeLen};

        // Drop picks that fall below the head.
        picked = anyReq && ({1'b0, shiftedGrant} >= lowBound);
    end

endmodule : CircularRangePicker


// Generic right shifter.
// Kept apart so a hand-built version can replace it for one width.
module CircularRangePickerRightShifter #(
    parameter INPUT_WIDTH = 16,
    parameter SHIFT_AMOUNT_WIDTH = 3,
    parameter OUTPUT_WIDTH = 8
)(
    input  logic [INPUT_WIDTH-1:0]        shiftIn,
    input  logic [SHIFT_AMOUNT_WIDTH-1:0] shiftAmount,
    output logic [OUTPUT_WIDTH-1:0]       shiftOut
);
    // Full-width shift result before truncation.
    logic [INPUT_WIDTH-1:0] shifted;

    always_comb begin
        shifted = shiftIn >> shiftAmount;
        shiftOut = shifted[OUTPUT_WIDTH-1:0];
    end

endmodule : CircularRangePickerRightShifter

//--- hw/StoreQueueStorage.sv
// Store queue entry array with head, commit and tail pointers; instantiated by the queue top.
`include "storeQueue_params.svh"

module StoreQueueStorage (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      allocValid,
    input  StoreQueuePkg::SqAddr      allocAddr,
    input  StoreQueuePkg::SqData      allocData,
    input  logic                      commitValid,
    input  logic                      drainDone,
    output StoreQueuePkg::SqPtr       headPtr,
    output StoreQueuePkg::SqPtr       tailPtr,
    output logic                      full,
    output logic                      headCommitted,
    output logic [`SQ_ENTRY_NUM-1:0]  entryValid,
    output StoreQueuePkg::SqAddr      entryAddr [`SQ_ENTRY_NUM],
    output StoreQueuePkg::SqData      entryData [`SQ_ENTRY_NUM]
);
    // Oldest uncommitted entry.
    StoreQueuePkg::SqPtr commitPtr;
    // Incremented pointers, wrapping at the entry count.
    StoreQueuePkg::SqPtr headInc;
    StoreQueuePkg::SqPtr commitInc;
    StoreQueuePkg::SqPtr tailInc;
    // Per-entry committed flags.
    logic [`SQ_ENTRY_NUM-1:0] committed;
    logic allocFire;
    logic commitFire;

    always_comb begin
        headInc = headPtr + 1'b1;
        commitInc = commitPtr + 1'b1;
        tailInc = tailPtr + 1'b1;
    end

    // One slot stays free, so full is tail one step behind head.
    assign full = (tailInc == headPtr);

    // Allocation is dropped while full.
    assign allocFire = allocValid && !full;

    // Commit stops at the tail; nothing uncommitted is left there.
    assign commitFire = commitValid && (commitPtr != tailPtr);

    // The drainer only looks at the head entry.
    assign headCommitted = entryValid[headPtr] && committed[headPtr];

    // Pointers and flags.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            headPtr <= '0;
            commitPtr <= '0;
            tailPtr <= '0;
            entryValid <= '0;
            committed <= '0;
        end
        else begin
            if (allocFire) begin
                entryValid[tailPtr] <= 1'b1;
                tailPtr <= tailInc;
            end
            if (commitFire) begin
                committed[commitPtr] <= 1'b1;
                commitPtr <= commitInc;
            end
            // Head is committed here, so it never equals commitPtr.
            if (drainDone) begin
                entryValid[headPtr] <= 1'b0;
                committed[headPtr] <= 1'b0;
                headPtr <= headInc;
            end
        end
    end

    // Store payload.
    always_ff @(posedge clk) begin
        if (allocFire) begin
            entryAddr[tailPtr] <= allocAddr;
            entryData[tailPtr] <= allocData;
        end
    end

endmodule : StoreQueueStorage

//--- hw/StoreForwarder.sv
// Store-to-load forwarding lookup with a one-cycle registered answer; used by the queue top.
`include "storeQueue_params.svh"

module StoreForwarder (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      loadValid,
    input  StoreQueuePkg::SqAddr      loadAddr,
    input  StoreQueuePkg::SqPtr       loadSqPtr,
    input  StoreQueuePkg::SqPtr       headPtr,
    input  logic [`SQ_ENTRY_NUM-1:0]  entryValid,
    input  StoreQueuePkg::SqAddr      entryAddr [`SQ_ENTRY_NUM],
    input  StoreQueuePkg::SqData      entryData [`SQ_ENTRY_NUM],
    output logic                      fwdValid,
    output logic                      fwdHit,
    output StoreQueuePkg::SqData      fwdData
);
    // Valid entries holding the load's word address.
    logic [`SQ_ENTRY_NUM-1:0] addrMatch;
    StoreQueuePkg::SqPtr grantPtr;
    logic picked;

    always_comb begin
        for (int i = 0; i < `SQ_ENTRY_NUM; i++) begin
            addrMatch[i] = entryValid[i] && (entryAddr[i] == loadAddr);
        end
    end

    // Youngest match older than the load.
    // loadSqPtr is exclusive, so stores allocated after dispatch are skipped.
    CircularRangePicker #(
        .ENTRY_NUM (`SQ_ENTRY_NUM)
    ) rangePicker (
        .headPtr  (headPtr),
        .tailPtr  (loadSqPtr),
        .request  (addrMatch),
        .grantPtr (grantPtr),
        .picked   (picked)
    );

    // Answer flags.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            fwdValid <= 1'b0;
            fwdHit <= 1'b0;
        end
        else begin
            fwdValid <= loadValid;
            fwdHit <= loadValid && picked;
        end
    end

    // Forwarded word, zero on a miss.
    always_ff @(posedge clk) begin
        fwdData <= (loadValid && picked) ? entryData[grantPtr] : '0;
    end

endmodule : StoreForwarder

//--- hw/StoreDrainer.sv
// In-order drain FSM that writes committed head stores to memory; used by the queue top.
`include "storeQueue_params.svh"

module StoreDrainer (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      headCommitted,
    input  StoreQueuePkg::SqPtr       headPtr,
    input  StoreQueuePkg::SqAddr      entryAddr [`SQ_ENTRY_NUM],
    input  StoreQueuePkg::SqData      entryData [`SQ_ENTRY_NUM],
    input  logic                      memAck,
    output logic                      memWrite,
    output StoreQueuePkg::SqAddr      memAddr,
    output StoreQueuePkg::SqData      memData,
    output logic                      drainDone
);
    StoreQueuePkg::DrainState state;
    logic startWrite;

    // A drainDone cycle still shows the old head, so wait for the pointer to move.
    assign startWrite = (state == StoreQueuePkg::DRAIN_IDLE) && headCommitted && !drainDone;

    // The request is a level for the whole write state.
    assign memWrite = (state == StoreQueuePkg::DRAIN_WRITE);

    // FSM and done pulse.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= StoreQueuePkg::DRAIN_IDLE;
            drainDone <= 1'b0;
        end
        else begin
            drainDone <= 1'b0;
            case (state)
                StoreQueuePkg::DRAIN_IDLE: begin
                    if (startWrite) begin
                        state <= StoreQueuePkg::DRAIN_WRITE;
                    end
                end
                StoreQueuePkg::DRAIN_WRITE: begin
                    // Held under back-pressure until the acknowledge.
                    if (memAck) begin
                        state <= StoreQueuePkg::DRAIN_IDLE;
                        drainDone <= 1'b1;
                    end
                end
                default: begin
                    state <= StoreQueuePkg::DRAIN_IDLE;
                end
            endcase
        end
    end

    // Head entry captured at the start of each write.
    always_ff @(posedge clk) begin
        if (startWrite) begin
            memAddr <= entryAddr[headPtr];
            memData <= entryData[headPtr];
        end
    end

endmodule : StoreDrainer

//--- hw/StoreQueue.sv
// Store queue top level; connects storage, forwarding and drain, the DUT of the testbench.
`include "storeQueue_params.svh"

module StoreQueue (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 allocValid,
    input  StoreQueuePkg::SqAddr allocAddr,
    input  StoreQueuePkg::SqData allocData,
    output StoreQueuePkg::SqPtr  tailPtr,
    output logic                 full,
    input  logic                 commitValid,
    input  logic                 loadValid,
    input  StoreQueuePkg::SqAddr loadAddr,
    input  StoreQueuePkg::SqPtr  loadSqPtr,
    output logic                 fwdValid,
    output logic                 fwdHit,
    output StoreQueuePkg::SqData fwdData,
    output logic                 memWrite,
    output StoreQueuePkg::SqAddr memAddr,
    output StoreQueuePkg::SqData memData,
    input  logic                 memAck
);
    // Entry state shared by the forwarder and the drainer.
    StoreQueuePkg::SqPtr headPtr;
    logic [`SQ_ENTRY_NUM-1:0] entryValid;
    StoreQueuePkg::SqAddr entryAddr [`SQ_ENTRY_NUM];
    StoreQueuePkg::SqData entryData [`SQ_ENTRY_NUM];
    logic headCommitted;
    // Frees the head entry.
    logic drainDone;

    StoreQueueStorage storage (
        .clk           (clk),
        .rstN          (rstN),
        .allocValid    (allocValid),
        .allocAddr     (allocAddr),
        .allocData     (allocData),
        .commitValid   (commitValid),
        .drainDone     (drainDone),
        .headPtr       (headPtr),
        .tailPtr       (tailPtr),
        .full          (full),
        .headCommitted (headCommitted),
        .entryValid    (entryValid),
        .entryAddr     (entryAddr),
        .entryData     (entryData)
    );

    StoreForwarder forwarder (
        .clk        (clk),
        .rstN       (rstN),
        .loadValid  (loadValid),
        .loadAddr   (loadAddr),
        .loadSqPtr  (loadSqPtr),
        .headPtr    (headPtr),
        .entryValid (entryValid),
        .entryAddr  (entryAddr),
        .entryData  (entryData),
        .fwdValid   (fwdValid),
        .fwdHit     (fwdHit),
        .fwdData    (fwdData)
    );

    StoreDrainer drainer (
        .clk           (clk),
        .rstN          (rstN),
        .headCommitted (headCommitted),
        .headPtr       (headPtr),
        .entryAddr     (entryAddr),
        .entryData     (entryData),
        .memAck        (memAck),
        .memWrite      (memWrite),
        .memAddr       (memAddr),
        .memData       (memData),
        .drainDone     (drainDone)
    );

endmodule : StoreQueue

//--- tb/StoreQueueTb.sv
// Directed testbench for the store queue; build with the file list, StoreQueueTb is the top.
`include "storeQueue_params.svh"

module StoreQueueTb;
    // One slot always stays free.
    localparam int Capacity = `SQ_ENTRY_NUM - 1;
    localparam int WaitLimit = 200;

    logic clk;
    logic rstN;
    logic allocValid;
    StoreQueuePkg::SqAddr allocAddr;
    StoreQueuePkg::SqData allocData;
    StoreQueuePkg::SqPtr tailPtr;
    logic full;
    logic commitValid;
    logic loadValid;
    StoreQueuePkg::SqAddr loadAddr;
    StoreQueuePkg::SqPtr loadSqPtr;
    logic fwdValid;
    logic fwdHit;
    StoreQueuePkg::SqData fwdData;
    logic memWrite;
    StoreQueuePkg::SqAddr memAddr;
    StoreQueuePkg::SqData memData;
    logic memAck;

    // Reference model; index 0 is the head entry.
    StoreQueuePkg::SqAddr modelAddr [$];
    StoreQueuePkg::SqData modelData [$];
    bit modelCommitted [$];
    StoreQueuePkg::SqPtr modelHead;
    StoreQueuePkg::SqPtr modelTail;

    // Tail positions recorded around the A1, B, A2 stores.
    StoreQueuePkg::SqPtr ptrHead;
    StoreQueuePkg::SqPtr ptrAfterA1;
    StoreQueuePkg::SqPtr ptrAfterB;
    StoreQueuePkg::SqPtr ptrAfterA2;

    logic [31:0] lcgState;
    int checkCount;
    int errorCount;
    bit aborted;

    StoreQueue u_dut (
        .clk         (clk),
        .rstN        (rstN),
        .allocValid  (allocValid),
        .allocAddr   (allocAddr),
        .allocData   (allocData),
        .tailPtr     (tailPtr),
        .full        (full),
        .commitValid (commitValid),
        .loadValid   (loadValid),
        .loadAddr    (loadAddr),
        .loadSqPtr   (loadSqPtr),
        .fwdValid    (fwdValid),
        .fwdHit      (fwdHit),
        .fwdData     (fwdData),
        .memWrite    (memWrite),
        .memAddr     (memAddr),
        .memData     (memData),
        .memAck      (memAck)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Value in 0..n-1 taken from the better upper bits.
    function automatic int randBelow(input int n);
        lcgState = lcgNext(lcgState);
        return int'(lcgState[30:16]) % n;
    endfunction

    function automatic StoreQueuePkg::SqData randWord();
        lcgState = lcgNext(lcgState);
        return lcgState;
    endfunction

    task automatic checkPtr(input string name, input StoreQueuePkg::SqPtr expected,
                            input StoreQueuePkg::SqPtr actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkData(input string name, input StoreQueuePkg::SqData expected,
                             input StoreQueuePkg::SqData actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    task automatic checkAddr(input string name, input StoreQueuePkg::SqAddr expected,
                             input StoreQueuePkg::SqAddr actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
        end
    endtask

    // Inputs change one unit after the edge, outputs are read there too.
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic reportTest(input string name, input int startErrors);
        $display("test %s finished with %0d errors", name, errorCount - startErrors);
    endtask

    // The model drops the store when the queue is full.
    task automatic allocStore(input StoreQueuePkg::SqAddr addr, input StoreQueuePkg::SqData data);
        allocValid = 1'b1;
        allocAddr = addr;
        allocData = data;
        nextCycle();
        allocValid = 1'b0;
        if (modelAddr.size() < Capacity) begin
            modelAddr.push_back(addr);
            modelData.push_back(data);
            modelCommitted.push_back(1'b0);
            modelTail = modelTail + 1'b1;
        end
        checkPtr("tailPtr", modelTail, tailPtr);
        checkBit("full", modelAddr.size() == Capacity, full);
    endtask

    // Marks the oldest uncommitted store; a no-op when none is left.
    task automatic commitStore();
        bit done;
        done = 1'b0;
        commitValid = 1'b1;
        nextCycle();
        commitValid = 1'b0;
        for (int i = 0; i < modelCommitted.size(); i++) begin
            if (!done && !modelCommitted[i]) begin
                modelCommitted[i] = 1'b1;
                done = 1'b1;
            end
        end
    endtask

    // Acts as memory for one write, with a random 0 to 3 cycle delay before memAck.
    task automatic drainOne();
        int cycles;
        int delay;
        cycles = 0;
        while (!memWrite && cycles < WaitLimit) begin
            nextCycle();
            cycles++;
        end
        if (!memWrite) begin
            $display("Timeout: no memory write within %0d cycles of a committed head", WaitLimit);
            errorCount++;
            aborted = 1'b1;
            return;
        end
        checkAddr("memAddr", modelAddr[0], memAddr);
        checkData("memData", modelData[0], memData);
        delay = randBelow(4);
        // Request must stay up under back-pressure.
        repeat (delay) begin
            nextCycle();
            checkBit("memWrite", 1'b1, memWrite);
        end
        memAck = 1'b1;
        nextCycle();
        memAck = 1'b0;
        checkBit("memWrite", 1'b0, memWrite);
        // Head moves at the edge after drainDone.
        nextCycle();
        void'(modelAddr.pop_front());
        void'(modelData.pop_front());
        void'(modelCommitted.pop_front());
        modelHead = modelHead + 1'b1;
    endtask

    // Youngest matching store from the model head up to ptr, ptr excluded.
    task automatic modelLookup(input StoreQueuePkg::SqAddr addr, input StoreQueuePkg::SqPtr ptr,
                               output bit hit, output StoreQueuePkg::SqData data);
        StoreQueuePkg::SqPtr span;
        span = ptr - modelHead;
        hit = 1'b0;
        data = '0;
        for (int i = 0; i < int'(span); i++) begin
            if (modelAddr[i] == addr) begin
                hit = 1'b1;
                data = modelData[i];
            end
        end
    endtask

    // The answer must come exactly one cycle after loadValid.
    task automatic lookupCheck(input StoreQueuePkg::SqAddr addr, input StoreQueuePkg::SqPtr ptr,
                               input bit expHit, input StoreQueuePkg::SqData expData);
        checkBit("fwdValid", 1'b0, fwdValid);
        loadValid = 1'b1;
        loadAddr = addr;
        loadSqPtr = ptr;
        nextCycle();
        loadValid = 1'b0;
        checkBit("fwdValid", 1'b1, fwdValid);
        checkBit("fwdHit", expHit, fwdHit);
        checkData("fwdData", expData, fwdData);
        nextCycle();
        checkBit("fwdValid", 1'b0, fwdValid);
    endtask

    task automatic testFill();
        int startErrors;
        startErrors = errorCount;
        checkBit("memWrite", 1'b0, memWrite);
        checkBit("fwdValid", 1'b0, fwdValid);
        checkBit("full", 1'b0, full);
        checkPtr("tailPtr", '0, tailPtr);
        for (int i = 0; i < Capacity; i++) begin
            allocStore(StoreQueuePkg::SqAddr'(16'h1000 + i), randWord());
        end
        // Queue is full here, so this one is dropped.
        allocStore(16'h1fff, 32'hdeadbeef);
        reportTest("fill", startErrors);
    endtask

    task automatic testDrain();
        int startErrors;
        startErrors = errorCount;
        for (int i = 0; i < Capacity && !aborted; i++) begin
            commitStore();
            drainOne();
            // Next head is still uncommitted.
            repeat (3) begin
                nextCycle();
                checkBit("memWrite", 1'b0, memWrite);
            end
        end
        checkBit("full", 1'b0, full);
        reportTest("drain", startErrors);
    endtask

    task automatic testYoungest();
        int startErrors;
        startErrors = errorCount;
        // Queue is empty, so the tail is also the head.
        ptrHead = tailPtr;
        allocStore(16'h0100, 32'ha1a1_0001);
        ptrAfterA1 = tailPtr;
        allocStore(16'h0200, 32'hb0b0_0002);
        ptrAfterB = tailPtr;
        allocStore(16'h0100, 32'ha2a2_0003);
        ptrAfterA2 = tailPtr;
        lookupCheck(16'h0100, ptrAfterA2, 1'b1, 32'ha2a2_0003);
        reportTest("youngest", startErrors);
    endtask

    task automatic testRange();
        int startErrors;
        startErrors = errorCount;
        lookupCheck(16'h0100, ptrAfterA1, 1'b1, 32'ha1a1_0001);
        lookupCheck(16'h0100, ptrAfterB, 1'b1, 32'ha1a1_0001);
        // B sits at the load's own position, outside the range.
        lookupCheck(16'h0200, ptrAfterA1, 1'b0, '0);
        // Empty range.
        lookupCheck(16'h0100, ptrHead, 1'b0, '0);
        lookupCheck(16'h0300, ptrAfterA2, 1'b0, '0);
        reportTest("range", startErrors);
    endtask

    task automatic testWrap();
        int startErrors;
        int allocs;
        int commits;
        bit expHit;
        StoreQueuePkg::SqData expData;
        StoreQueuePkg::SqAddr addr;
        StoreQueuePkg::SqPtr ptr;
        startErrors = errorCount;
        for (int round = 0; round < 40 && !aborted; round++) begin
            allocs = randBelow(3) + 1;
            repeat (allocs) begin
                allocStore(StoreQueuePkg::SqAddr'(16'h0040 + randBelow(4)), randWord());
            end
            // Small address set keeps matches frequent.
            repeat (2) begin
                addr = StoreQueuePkg::SqAddr'(16'h0040 + randBelow(4));
                ptr = modelHead + StoreQueuePkg::SqPtr'(randBelow(modelAddr.size() + 1));
                modelLookup(addr, ptr, expHit, expData);
                lookupCheck(addr, ptr, expHit, expData);
            end
            commits = randBelow(3);
            repeat (commits) begin
                commitStore();
            end
            while (modelCommitted.size() > 0 && modelCommitted[0] && !aborted) begin
                drainOne();
            end
        end
        reportTest("wrap", startErrors);
    endtask

    initial begin
        rstN = 1'b0;
        allocValid = 1'b0;
        allocAddr = '0;
        allocData = '0;
        commitValid = 1'b0;
        loadValid = 1'b0;
        loadAddr = '0;
        loadSqPtr = '0;
        memAck = 1'b0;
        modelHead = '0;
        modelTail = '0;
        lcgState = 32'd90;
        checkCount = 0;
        errorCount = 0;
        aborted = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        testFill();
        if (!aborted) testDrain();
        if (!aborted) testYoungest();
        if (!aborted) testRange();
        if (!aborted) testWrap();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : StoreQueueTb

//--- StoreQueue.f
+incdir+hw
hw/StoreQueuePkg.sv
hw/CircularRangePicker.sv
hw/StoreQueueStorage.sv
hw/StoreForwarder.sv
hw/StoreDrainer.sv
hw/StoreQueue.sv
tb/StoreQueueTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= StoreQueueTb
FILELIST ?= StoreQueue.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator status is ignored here; the log search decides pass or fail.
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
